/* project.f */
rtl/mk14_mem_pkg.sv
rtl/tm1638_pkg.sv
rtl/dual_port_ram.sv
rtl/seg7_frame_scanner.sv
rtl/tm1638_shifter.sv
rtl/mk14_display_soc.sv
test/mk14_display_properties.sv
test/mk14_display_tb.sv

/* rtl/dual_port_ram.sv */
// Main RAM of the display SoC, port A for the host and port B for the display scanner
module dual_port_ram
	import mk14_mem_pkg::*;
(
	input  logic              clk,

	// Host port, write and registered read
	input  logic              i_a_we,
	input  logic [ADDR_W-1:0] i_a_addr,
	input  byte               i_a_wdata,
	output byte               o_a_rdata,

	// Display port, registered read only
	input  logic [ADDR_W-1:0] i_b_addr,
	output byte               o_b_rdata
);

	byte mem [RAM_DEPTH];

	// A read on port A in the cycle of a write returns the old byte
	always_ff @(posedge clk) begin
		if (i_a_we) begin
			mem[i_a_addr] <= i_a_wdata;
		end
		o_a_rdata <= mem[i_a_addr];
	end

	// The scanner holds its address while stalled, so this output
	// follows any host write into the window a cycle later
	always_ff @(posedge clk) begin
		o_b_rdata <= mem[i_b_addr];
	end

endmodule

/* rtl/mk14_display_soc.sv */
// Top level of the MK14 display SoC, host RAM port plus periodic refresh of the TM1638 board
module mk14_display_soc
	import mk14_mem_pkg::*;
	import tm1638_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// Host port standing in for the CPU core
	input  logic              i_host_we,
	input  logic [ADDR_W-1:0] i_host_addr,
	input  byte               i_host_wdata,
	output byte               o_host_rdata,

	output logic              o_idle,

	output logic              o_tm1638_clk,
	output logic              o_tm1638_stb,
	output logic              o_tm1638_dio
);

	logic [REFRESH_W-1:0] refresh_q;
	logic                 start_q;
	logic [ADDR_W-1:0]    disp_addr;
	byte                  disp_rdata;
	logic                 scan_busy;
	logic                 scan_push;
	tm1638_byte_u         scan_byte;
	logic                 scan_last;
	logic                 shf_credit;
	logic                 shf_active;

	assign o_idle = !scan_busy && !shf_active;

	// Refresh countdown, a frame starts only if the previous one has drained
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			refresh_q <= REFRESH_W'(REFRESH_CYCLES - 1);
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (refresh_q == '0) begin
				refresh_q <= REFRESH_W'(REFRESH_CYCLES - 1);
				if (o_idle) start_q <= 1'b1;
			end else begin
				refresh_q <= refresh_q - 1'b1;
			end
		end
	end

	dual_port_ram ram_i (
		.clk       (clk),
		.i_a_we    (i_host_we),
		.i_a_addr  (i_host_addr),
		.i_a_wdata (i_host_wdata),
		.o_a_rdata (o_host_rdata),
		.i_b_addr  (disp_addr),
		.o_b_rdata (disp_rdata)
	);

	seg7_frame_scanner scanner_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_start   (start_q),
		.o_busy    (scan_busy),
		.o_rd_addr (disp_addr),
		.i_rd_data (disp_rdata),
		.o_push    (scan_push),
		.o_byte    (scan_byte),
		.o_last    (scan_last),
		.i_credit  (shf_credit)
	);

	tm1638_shifter shifter_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_push       (scan_push),
		.i_byte       (scan_byte),
		.i_last       (scan_last),
		.o_credit     (shf_credit),
		.o_active     (shf_active),
		.o_tm1638_clk (o_tm1638_clk),
		.o_tm1638_stb (o_tm1638_stb),
		.o_tm1638_dio (o_tm1638_dio)
	);

endmodule

/* rtl/mk14_mem_pkg.sv */
// Memory map of the MK14 display SoC, imported by the RAM, the frame scanner and the top level
package mk14_mem_pkg;

	// Main RAM, 4 KiB of bytes as on the trainer
	localparam int RAM_DEPTH = 4096;
	localparam int ADDR_W = $clog2(RAM_DEPTH);

	// Eight seven-segment digits mapped one byte each from this address
	localparam logic [ADDR_W-1:0] SEG7_BASE_ADDR = ADDR_W'('h100);
	localparam int SEG7_COUNT = 8;

	// One extra code so the digit counter can run one past the last digit
	localparam int DIGIT_W = $clog2(SEG7_COUNT + 1);

	// Clocks between two refresh attempts of the LED board
	localparam int REFRESH_CYCLES = 2000;
	localparam int REFRESH_W = $clog2(REFRESH_CYCLES);

endpackage

/* rtl/seg7_frame_scanner.sv */
// Walks one TM1638 frame, reading the segment window from RAM and pushing bytes under credits
module seg7_frame_scanner
	import mk14_mem_pkg::*;
	import tm1638_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_start,
	output logic              o_busy,

	// Display read port of the RAM
	output logic [ADDR_W-1:0] o_rd_addr,
	input  byte               i_rd_data,

	// Byte stream to the shifter
	output logic              o_push,
	output tm1638_byte_u      o_byte,
	output logic              o_last,
	input  logic              i_credit
);

	logic [2:0]          state_q;
	logic [DIGIT_W-1:0]  digit_q;
	logic [CREDIT_W-1:0] credit_q;
	logic                take;
	logic                last_digit;
	tm1638_byte_u        next_byte;
	logic                next_last;

	assign o_busy = (state_q != SCAN_IDLE);
	assign o_rd_addr = SEG7_BASE_ADDR + ADDR_W'(digit_q);
	assign last_digit = (digit_q == DIGIT_W'(SEG7_COUNT));

	// Every non-idle state pushes exactly one byte once a credit is there
	assign take = o_busy && (credit_q != '0);

	always_comb begin
		next_byte = '0;
		next_last = 1'b0;
		case (state_q)
			SCAN_DATA_CMD: begin
				next_byte.cmd = tm1638_cmd_s'(CMD_DATA_AUTO_INC);
				next_last = 1'b1;
			end
			SCAN_ADDR_CMD: next_byte.cmd = tm1638_cmd_s'(CMD_ADDR_ZERO);
			SCAN_SEG: next_byte.raw = i_rd_data;
			// LED bytes stay zero, the last one closes the address group
			SCAN_LED: next_last = last_digit;
			SCAN_DISP_CMD: begin
				next_byte.cmd = tm1638_cmd_s'(CMD_DISPLAY_ON);
				next_last = 1'b1;
			end
			default: next_last = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= SCAN_IDLE;
			digit_q <= '0;
			credit_q <= CREDIT_W'(FIFO_DEPTH);
			o_push <= 1'b0;
		end else begin
			o_push <= take;
			credit_q <= credit_q + CREDIT_W'(i_credit) - CREDIT_W'(take);
			case (state_q)
				SCAN_IDLE: if (i_start) begin
					digit_q <= '0;
					state_q <= SCAN_DATA_CMD;
				end
				SCAN_DATA_CMD: if (take) state_q <= SCAN_ADDR_CMD;
				SCAN_ADDR_CMD: if (take) state_q <= SCAN_SEG;
				// Step the digit here so the next address is on the bus during the LED byte
				SCAN_SEG: if (take) begin
					digit_q <= digit_q + 1'b1;
					state_q <= SCAN_LED;
				end
				SCAN_LED: if (take) state_q <= last_digit ? SCAN_DISP_CMD : SCAN_SEG;
				SCAN_DISP_CMD: if (take) state_q <= SCAN_IDLE;
				default: state_q <= SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			o_byte <= next_byte;
			o_last <= next_last;
		end
	end

endmodule

/* rtl/tm1638_pkg.sv */
// TM1638 serial bus definitions, imported by the frame scanner, the shifter and the top level
package tm1638_pkg;

	// Command kind lives in the two top bits of a leading byte
	localparam logic [1:0] CMD_KIND_DATA = 2'b01;
	localparam logic [1:0] CMD_KIND_DISPLAY = 2'b10;
	localparam logic [1:0] CMD_KIND_ADDR = 2'b11;

	typedef struct packed {
		logic [1:0] kind;
		logic [5:0] arg;
	} tm1638_cmd_s;

	// The same bus byte read as a command or as a raw segment pattern
	typedef union packed {
		tm1638_cmd_s cmd;
		logic [7:0]  raw;
	} tm1638_byte_u;

	localparam logic [7:0] CMD_DATA_AUTO_INC = 8'h40;
	localparam logic [7:0] CMD_ADDR_ZERO = 8'hc0;
	localparam logic [7:0] CMD_DISPLAY_ON = 8'h8f;

	// Bus clock timing, a bit is one low and one high half
	localparam int HALF_BIT_CYCLES = 4;
	localparam int TIMER_W = $clog2(2 * HALF_BIT_CYCLES);

	// Byte FIFO between scanner and shifter, also the initial credit count
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

	// Frame scanner states
	localparam logic [2:0] SCAN_IDLE = 3'd0;
	localparam logic [2:0] SCAN_DATA_CMD = 3'd1;
	localparam logic [2:0] SCAN_ADDR_CMD = 3'd2;
	localparam logic [2:0] SCAN_SEG = 3'd3;
	localparam logic [2:0] SCAN_LED = 3'd4;
	localparam logic [2:0] SCAN_DISP_CMD = 3'd5;

	// Serializer states
	localparam logic [2:0] SHF_IDLE = 3'd0;
	localparam logic [2:0] SHF_START = 3'd1;
	localparam logic [2:0] SHF_LOW = 3'd2;
	localparam logic [2:0] SHF_HIGH = 3'd3;
	localparam logic [2:0] SHF_HOLD = 3'd4;
	localparam logic [2:0] SHF_GAP = 3'd5;

endpackage

/* rtl/tm1638_shifter.sv */
// Buffers bus bytes in a small FIFO and shifts them out on the TM1638 clock, strobe and data pins
module tm1638_shifter
	import tm1638_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	// Byte stream from the scanner, one credit returned per pop
	input  logic         i_push,
	input  tm1638_byte_u i_byte,
	input  logic         i_last,
	output logic         o_credit,
	output logic         o_active,

	output logic         o_tm1638_clk,
	output logic         o_tm1638_stb,
	output logic         o_tm1638_dio
);

	logic [8:0]          fifo_mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0]  wr_ptr_q;
	logic [FIFO_AW-1:0]  rd_ptr_q;
	logic [CREDIT_W-1:0] count_q;
	logic [2:0]          state_q;
	logic [TIMER_W-1:0]  timer_q;
	logic [2:0]          bit_q;
	logic [7:0]          shreg_q;
	logic                last_q;
	logic                half_done;
	logic                byte_done;
	logic                step;
	logic                pop;
	logic [7:0]          head_byte;
	logic                head_last;

	assign {head_last, head_byte} = fifo_mem[rd_ptr_q];
	assign half_done = (timer_q == TIMER_W'(HALF_BIT_CYCLES - 1));
	assign byte_done = (state_q == SHF_HIGH) && half_done && (bit_q == 3'd7);
	assign step = (state_q == SHF_HIGH) && half_done && (bit_q != 3'd7);

	// Load the next byte after the strobe lead-in, or straight after a byte inside a group
	assign pop = (count_q != '0) &&
		(((state_q == SHF_START) && half_done) || (byte_done && !last_q) ||
		(state_q == SHF_HOLD));

	assign o_active = i_push || (count_q != '0) || (state_q != SHF_IDLE);

	always_ff @(posedge clk) begin
		if (i_push) begin
			fifo_mem[wr_ptr_q] <= {i_last, i_byte.raw};
		end
		if (pop) begin
			shreg_q <= head_byte;
			last_q <= head_last;
		end else if (step) begin
			shreg_q <= shreg_q >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			state_q <= SHF_IDLE;
			timer_q <= '0;
			bit_q <= '0;
			o_credit <= 1'b0;
			o_tm1638_clk <= 1'b1;
			o_tm1638_stb <= 1'b1;
			o_tm1638_dio <= 1'b1;
		end else begin
			o_credit <= pop;
			count_q <= count_q + CREDIT_W'(i_push) - CREDIT_W'(pop);
			if (i_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
			timer_q <= timer_q + 1'b1;

			if (pop) begin
				// First bit goes out as the clock falls
				state_q <= SHF_LOW;
				timer_q <= '0;
				bit_q <= '0;
				o_tm1638_clk <= 1'b0;
				o_tm1638_dio <= head_byte[0];
			end else begin
				case (state_q)
					SHF_IDLE: if (count_q != '0) begin
						o_tm1638_stb <= 1'b0;
						timer_q <= '0;
						state_q <= SHF_START;
					end
					SHF_LOW: if (half_done) begin
						o_tm1638_clk <= 1'b1;
						timer_q <= '0;
						state_q <= SHF_HIGH;
					end
					SHF_HIGH: if (half_done) begin
						timer_q <= '0;
						if (step) begin
							bit_q <= bit_q + 1'b1;
							o_tm1638_clk <= 1'b0;
							o_tm1638_dio <= shreg_q[1];
							state_q <= SHF_LOW;
						end else if (last_q) begin
							o_tm1638_stb <= 1'b1;
							state_q <= SHF_GAP;
						end else begin
							state_q <= SHF_HOLD;
						end
					end
					// Strobe stays high one full bit before the next group
					SHF_GAP: if (timer_q == TIMER_W'(2 * HALF_BIT_CYCLES - 1)) begin
						state_q <= SHF_IDLE;
					end
					SHF_START, SHF_HOLD: state_q <= state_q;
					default: state_q <= SHF_IDLE;
				endcase
			end
		end
	end

endmodule

/* test/mk14_display_properties.sv */
// Concurrent checks on the scanner credits and the shifter pins that the testbench binds into the RTL
module mk14_display_properties
	import tm1638_pkg::*;
(
	input logic                clk,
	input logic                rst_n,
	input logic [CREDIT_W-1:0] i_credit_cnt,
	input logic [CREDIT_W-1:0] i_fifo_level,
	input logic                i_bus_clk,
	input logic                i_bus_stb,
	input logic                i_bus_dio
);

	timeunit 1ns;
	timeprecision 100ps;

	// Credits come back only for pushed bytes and a push with no credit would wrap the count
	credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		i_credit_cnt <= CREDIT_W'(FIFO_DEPTH))
		else $error("credit count above the FIFO depth");

	fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		i_fifo_level <= CREDIT_W'(FIFO_DEPTH))
		else $error("shifter FIFO holds more bytes than its depth");

	stb_moves_clk_high: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(i_bus_stb) |-> i_bus_clk && $past(i_bus_clk))
		else $error("strobe changed while the bus clock was low");

	// The board samples on the rising bus clock
	dio_stable_clk_high: assert property (@(posedge clk) disable iff (!rst_n)
		i_bus_clk && $past(i_bus_clk) |-> $stable(i_bus_dio))
		else $error("data line changed while the bus clock was high");

endmodule

/* test/mk14_display_tb.sv */
// Random-stimulus testbench for the display SoC that decodes the TM1638 pins against a RAM model
module mk14_display_tb
	import mk14_mem_pkg::*;
	import tm1638_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Ten frames run including the one the live update skips
	// Worst case each of them waits one refresh period plus 19 bytes on the bus
	localparam int FRAMES_TESTED = 10;
	localparam int TIMEOUT_CYCLES =
		FRAMES_TESTED * (REFRESH_CYCLES + 19 * 16 * HALF_BIT_CYCLES + 200);

	logic              clk;
	logic              rst_n;
	logic              i_host_we;
	logic [ADDR_W-1:0] i_host_addr;
	byte               i_host_wdata;
	byte               o_host_rdata;
	logic              o_idle;
	logic              o_tm1638_clk;
	logic              o_tm1638_stb;
	logic              o_tm1638_dio;

	logic [31:0]  lfsr_q = 32'hb721_1635;
	byte          ram_model [RAM_DEPTH];
	int           cycle = 0;
	int           last_write = 0;
	int           checks = 0;
	int           errors = 0;
	logic [7:0]   rx_byte;
	int           rx_bits;
	byte          grp_q [$];
	int           grp_idx = 0;
	int           frame_start;
	int           done_start;
	int           frames_done = 0;
	byte          seg_rx [SEG7_COUNT];
	byte          frame_seg [SEG7_COUNT];
	tm1638_byte_u lead;

	mk14_display_soc dut_i (.*);

	bind seg7_frame_scanner mk14_display_properties scanner_props_i (
		.clk(clk), .rst_n(rst_n), .i_credit_cnt(credit_q),
		.i_fifo_level('0), .i_bus_clk(1'b1), .i_bus_stb(1'b1), .i_bus_dio(1'b1));
	bind tm1638_shifter mk14_display_properties shifter_props_i (
		.clk(clk), .rst_n(rst_n), .i_credit_cnt('0),
		.i_fifo_level(count_q), .i_bus_clk(o_tm1638_clk), .i_bus_stb(o_tm1638_stb),
		.i_bus_dio(o_tm1638_dio));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle++;

	initial begin
		wait (cycle > TIMEOUT_CYCLES);
		$display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// Write with auto-increment and address zero both carry an all-zero argument
	function automatic tm1638_cmd_s group_cmd(input int idx);
		case (idx)
			0: return {CMD_KIND_DATA, 6'h00};
			1: return {CMD_KIND_ADDR, 6'h00};
			// Display on with the highest brightness
			default: return {CMD_KIND_DISPLAY, 6'h0f};
		endcase
	endfunction

	task automatic check_byte(input string name, input byte exp, input byte act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cmd(input string name, input tm1638_cmd_s exp, input tm1638_cmd_s act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected kind %b arg %h, actual kind %b arg %h",
				name, exp.kind, exp.arg, act.kind, act.arg);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_idle_pins(input string name);
		check_flag({name, " strobe"}, 1'b1, o_tm1638_stb);
		check_flag({name, " bus clock"}, 1'b1, o_tm1638_clk);
		check_flag({name, " data"}, 1'b1, o_tm1638_dio);
		check_flag({name, " idle"}, 1'b1, o_idle);
	endtask

	task automatic host_write(input logic [ADDR_W-1:0] addr, input byte data);
		@(posedge clk);
		#2;
		i_host_we = 1'b1;
		i_host_addr = addr;
		i_host_wdata = data;
		@(posedge clk);
		#2;
		i_host_we = 1'b0;
		ram_model[addr] = data;
		// The display port sees the byte one cycle after the write edge
		last_write = cycle + 1;
	endtask

	task automatic host_read_check(input logic [ADDR_W-1:0] addr);
		@(posedge clk);
		#2;
		i_host_addr = addr;
		@(posedge clk);
		#2;
		check_byte("host read", ram_model[addr], o_host_rdata);
	endtask

	task automatic write_window(input int gap_bits);
		for (int i = 0; i < SEG7_COUNT; i++) begin
			repeat (rand_bits(gap_bits)) @(posedge clk);
			host_write(SEG7_BASE_ADDR + ADDR_W'(i), byte'(rand_bits(8)));
		end
	endtask

	// Returns once a frame that began after the last host write has ended
	task automatic wait_frame();
		int seen;
		do begin
			seen = frames_done;
			wait (frames_done != seen);
		end while (done_start <= last_write);
	endtask

	task automatic check_window(input string name);
		for (int i = 0; i < SEG7_COUNT; i++) begin
			check_byte($sformatf("%s digit %0d", name, i),
				ram_model[SEG7_BASE_ADDR + i], frame_seg[i]);
		end
	endtask

	always @(negedge o_tm1638_stb) begin
		rx_bits = 0;
		grp_q.delete();
		if (grp_idx == 0) frame_start = cycle;
	end

	always @(posedge o_tm1638_clk) begin
		if (!o_tm1638_stb) begin
			rx_byte = {o_tm1638_dio, rx_byte[7:1]};
			rx_bits++;
			if (rx_bits == 8) begin
				grp_q.push_back(rx_byte);
				rx_bits = 0;
			end
		end
	end

	// A rising strobe closes a group and three groups make a frame
	always @(posedge o_tm1638_stb) begin
		if (rst_n) begin
			lead.raw = (grp_q.size() > 0) ? grp_q[0] : 8'h00;
			check_byte($sformatf("group %0d length", grp_idx),
				byte'((grp_idx == 1) ? 2 * SEG7_COUNT + 1 : 1), byte'(grp_q.size()));
			check_cmd($sformatf("group %0d command", grp_idx), group_cmd(grp_idx), lead.cmd);
			if (grp_idx == 1 && grp_q.size() == 2 * SEG7_COUNT + 1) begin
				for (int i = 0; i < SEG7_COUNT; i++) begin
					seg_rx[i] = grp_q[2 * i + 1];
					check_byte($sformatf("LED byte %0d", i), 8'h00, grp_q[2 * i + 2]);
				end
			end
			if (grp_idx == 2) begin
				frame_seg = seg_rx;
				done_start = frame_start;
				frames_done++;
			end
			grp_idx = (grp_idx + 1) % 3;
		end
	end

	initial begin
		logic [ADDR_W-1:0] addr;
		i_host_we = 1'b0;
		i_host_addr = '0;
		i_host_wdata = 8'h00;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2 check_idle_pins("in reset");
		repeat (2) @(posedge clk);
		#2 rst_n = 1'b1;
		@(posedge clk);
		#2 check_idle_pins("after reset");

		write_window(0);
		wait_frame();
		check_window("segment content");

		// New values land while a frame is on the bus
		wait (o_idle);
		wait (!o_idle);
		write_window(7);
		wait_frame();
		check_window("live update");

		for (int i = 0; i < 16; i++) begin
			addr = ADDR_W'(rand_bits(ADDR_W));
			if (addr >= SEG7_BASE_ADDR && addr < SEG7_BASE_ADDR + SEG7_COUNT) begin
				addr[ADDR_W-1] = ~addr[ADDR_W-1];
			end
			host_write(addr, byte'(rand_bits(8)));
			host_read_check(addr);
		end
		wait_frame();
		check_window("window isolation");

		// The scanner outruns the bus, so these frames run on credits alone
		for (int f = 0; f < 6; f++) begin
			wait_frame();
			check_window($sformatf("back-pressure frame %0d", f));
		end

		$display("Checks %0d, errors %0d, frames %0d", checks, errors, frames_done);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
